/* beat_counter.sv */
// Counts remaining beats of one burst and needs i_load before each new burst
`default_nettype none

module beat_counter (
  input  var logic                      i_clk,
  input  var logic                      i_rst_n,
  input  var logic                      i_load,
  input  var corebus_pkg::corebus_len_t i_len,
  input  var logic                      i_step,
  output logic                          o_last
);
  import corebus_pkg::*;

  corebus_len_t remain; // Beats left after the current one

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      remain <= '0;
    end else if (i_load) begin
      remain <= i_len;
    end else if (i_step && (remain != '0)) begin
      remain <= remain - corebus_len_t'(1);
    end
  end

  assign o_last = (remain == '0);

endmodule

`default_nettype wire

/* corebus_pkg.sv */
// Widths and the address map are fixed here and bursts are limited to 1 to 4 beats
`default_nettype none

package corebus_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;
  localparam int LEN_W  = 2; // Beat count minus one

  typedef logic [ADDR_W-1:0] corebus_addr_t;
  typedef logic [DATA_W-1:0] corebus_data_t;
  typedef logic [ID_W-1:0]   corebus_id_t;
  typedef logic [LEN_W-1:0]  corebus_len_t;

  typedef enum logic [1:0] {
    CMD_READ,
    CMD_WRITE,   // Non-posted, one response
    CMD_MESSAGE  // Posted, one data beat and no response
  } corebus_cmd_e;

  typedef enum logic {
    RESP_PLAIN,
    RESP_WITH_DATA
  } corebus_resp_e;

  typedef struct packed {
    corebus_cmd_e  kind;
    corebus_id_t   id;
    corebus_addr_t addr;
    corebus_len_t  len;
  } corebus_cmd_s;

  typedef struct packed {
    corebus_data_t data;
    logic          last;
  } corebus_wdata_s;

  typedef struct packed {
    corebus_resp_e kind;
    corebus_id_t   id;
    logic          error;
    corebus_data_t data;
    logic          last;
  } corebus_resp_s;

  // Upper address nibble that selects the memory
  localparam logic [3:0] MEM_BASE_SEL = 4'h0;
  localparam int MEM_WORDS = 16;

  localparam corebus_data_t DUMMY_DATA = 32'hdead_beaf;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DRAIN,
    ST_RESP
  } dummy_state_e;

endpackage

`default_nettype wire

/* corebus_router.sv */
// Routes by upper address nibble and expects write data only after its command
`default_nettype none

module corebus_router (
  input  var logic                        i_clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_cmd_valid,
  input  var corebus_pkg::corebus_cmd_s   i_cmd,
  output logic                            o_cmd_accept,
  input  var logic                        i_wdata_valid,
  input  var corebus_pkg::corebus_wdata_s i_wdata,
  output logic                            o_wdata_accept,
  output logic                            o_resp_valid,
  output corebus_pkg::corebus_resp_s      o_resp,
  input  var logic                        i_resp_accept,
  output logic                            o_m_cmd_valid,
  output corebus_pkg::corebus_cmd_s       o_m_cmd,
  input  var logic                        i_m_cmd_accept,
  output logic                            o_m_wdata_valid,
  output corebus_pkg::corebus_wdata_s     o_m_wdata,
  input  var logic                        i_m_wdata_accept,
  input  var logic                        i_m_resp_valid,
  input  var corebus_pkg::corebus_resp_s  i_m_resp,
  output logic                            o_m_resp_accept,
  output logic                            o_d_cmd_valid,
  output corebus_pkg::corebus_cmd_s       o_d_cmd,
  input  var logic                        i_d_cmd_accept,
  output logic                            o_d_wdata_valid,
  output corebus_pkg::corebus_wdata_s     o_d_wdata,
  input  var logic                        i_d_wdata_accept,
  input  var logic                        i_d_resp_valid,
  input  var corebus_pkg::corebus_resp_s  i_d_resp,
  output logic                            o_d_resp_accept
);
  import corebus_pkg::*;

  logic sel_mem;
  logic cmd_fire;
  logic wd_active; // Write data owed to a target
  logic wd_to_mem;
  logic lock_active;
  logic lock_mem;
  logic grant_mem;

  // Command path
  assign sel_mem       = (i_cmd.addr[ADDR_W-1 -: 4] == MEM_BASE_SEL);
  assign o_m_cmd_valid = i_cmd_valid && sel_mem;
  assign o_d_cmd_valid = i_cmd_valid && !sel_mem;
  assign o_m_cmd       = i_cmd;
  assign o_d_cmd       = i_cmd;
  assign o_cmd_accept  = sel_mem ? i_m_cmd_accept : i_d_cmd_accept;
  assign cmd_fire      = i_cmd_valid && o_cmd_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wd_active <= 1'b0;
      wd_to_mem <= 1'b0;
    end else if (cmd_fire && (i_cmd.kind != CMD_READ)) begin
      wd_active <= 1'b1;
      wd_to_mem <= sel_mem;
    end else if (i_wdata_valid && o_wdata_accept && i_wdata.last) begin
      wd_active <= 1'b0;
    end
  end

  assign o_m_wdata_valid = i_wdata_valid && wd_active && wd_to_mem;
  assign o_d_wdata_valid = i_wdata_valid && wd_active && !wd_to_mem;
  assign o_m_wdata       = i_wdata;
  assign o_d_wdata       = i_wdata;
  assign o_wdata_accept  = wd_active && (wd_to_mem ? i_m_wdata_accept : i_d_wdata_accept);

  // Memory wins a tie, then the lock keeps the burst together
  assign grant_mem = lock_active ? lock_mem : i_m_resp_valid;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      lock_active <= 1'b0;
      lock_mem    <= 1'b0;
    end else if (o_resp_valid && i_resp_accept && o_resp.last) begin
      lock_active <= 1'b0;
    end else if (o_resp_valid) begin
      lock_active <= 1'b1; // Held also under back-pressure
      lock_mem    <= grant_mem;
    end
  end

  assign o_resp_valid    = grant_mem ? i_m_resp_valid : i_d_resp_valid;
  assign o_resp          = grant_mem ? i_m_resp : i_d_resp;
  assign o_m_resp_accept = i_resp_accept && grant_mem;
  assign o_d_resp_accept = i_resp_accept && !grant_mem;

endmodule

`default_nettype wire

/* corebus_subsystem.sv */
// Bus segment top with the memory at upper nibble 0 and the error target elsewhere
`default_nettype none

module corebus_subsystem (
  input  var logic                        i_clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_cmd_valid,
  input  var corebus_pkg::corebus_cmd_s   i_cmd,
  output logic                            o_cmd_accept,
  input  var logic                        i_wdata_valid,
  input  var corebus_pkg::corebus_wdata_s i_wdata,
  output logic                            o_wdata_accept,
  output logic                            o_resp_valid,
  output corebus_pkg::corebus_resp_s      o_resp,
  input  var logic                        i_resp_accept
);
  import corebus_pkg::*;

  logic           m_cmd_valid;
  corebus_cmd_s   m_cmd;
  logic           m_cmd_accept;
  logic           m_wdata_valid;
  corebus_wdata_s m_wdata;
  logic           m_wdata_accept;
  logic           m_resp_valid;
  corebus_resp_s  m_resp;
  logic           m_resp_accept;
  logic           d_cmd_valid;
  corebus_cmd_s   d_cmd;
  logic           d_cmd_accept;
  logic           d_wdata_valid;
  corebus_wdata_s d_wdata;
  logic           d_wdata_accept;
  logic           d_resp_valid;
  corebus_resp_s  d_resp;
  logic           d_resp_accept;

  corebus_router u_router (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_cmd_valid      (i_cmd_valid),
    .i_cmd            (i_cmd),
    .o_cmd_accept     (o_cmd_accept),
    .i_wdata_valid    (i_wdata_valid),
    .i_wdata          (i_wdata),
    .o_wdata_accept   (o_wdata_accept),
    .o_resp_valid     (o_resp_valid),
    .o_resp           (o_resp),
    .i_resp_accept    (i_resp_accept),
    .o_m_cmd_valid    (m_cmd_valid),
    .o_m_cmd          (m_cmd),
    .i_m_cmd_accept   (m_cmd_accept),
    .o_m_wdata_valid  (m_wdata_valid),
    .o_m_wdata        (m_wdata),
    .i_m_wdata_accept (m_wdata_accept),
    .i_m_resp_valid   (m_resp_valid),
    .i_m_resp         (m_resp),
    .o_m_resp_accept  (m_resp_accept),
    .o_d_cmd_valid    (d_cmd_valid),
    .o_d_cmd          (d_cmd),
    .i_d_cmd_accept   (d_cmd_accept),
    .o_d_wdata_valid  (d_wdata_valid),
    .o_d_wdata        (d_wdata),
    .i_d_wdata_accept (d_wdata_accept),
    .i_d_resp_valid   (d_resp_valid),
    .i_d_resp         (d_resp),
    .o_d_resp_accept  (d_resp_accept)
  );

  sram_target u_sram (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_cmd_valid    (m_cmd_valid),
    .i_cmd          (m_cmd),
    .o_cmd_accept   (m_cmd_accept),
    .i_wdata_valid  (m_wdata_valid),
    .i_wdata        (m_wdata),
    .o_wdata_accept (m_wdata_accept),
    .o_resp_valid   (m_resp_valid),
    .o_resp         (m_resp),
    .i_resp_accept  (m_resp_accept)
  );

  dummy_target u_dummy (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_cmd_valid    (d_cmd_valid),
    .i_cmd          (d_cmd),
    .o_cmd_accept   (d_cmd_accept),
    .i_wdata_valid  (d_wdata_valid),
    .i_wdata        (d_wdata),
    .o_wdata_accept (d_wdata_accept),
    .o_resp_valid   (d_resp_valid),
    .o_resp         (d_resp),
    .i_resp_accept  (d_resp_accept)
  );

endmodule

`default_nettype wire

/* dummy_responder_fsm.sv */
// Handshake control of the default target and serves one command at a time
`default_nettype none

module dummy_responder_fsm (
  input  var logic                      i_clk,
  input  var logic                      i_rst_n,
  input  var logic                      i_cmd_fire,
  input  var corebus_pkg::corebus_cmd_e i_cmd_kind,
  input  var logic                      i_wdata_fire,
  input  var logic                      i_wdata_last,
  input  var logic                      i_resp_fire,
  input  var logic                      i_resp_last,
  output logic                          o_cmd_accept,
  output logic                          o_wdata_accept,
  output logic                          o_resp_valid
);
  import corebus_pkg::*;

  dummy_state_e state;
  dummy_state_e state_next;
  logic         is_msg; // Drained command was posted

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (i_cmd_fire) begin
          state_next = (i_cmd_kind == CMD_READ) ? ST_RESP : ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        if (i_wdata_fire && i_wdata_last) begin
          state_next = is_msg ? ST_IDLE : ST_RESP;
        end
      end
      ST_RESP: begin
        if (i_resp_fire && i_resp_last) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state  <= ST_IDLE;
      is_msg <= 1'b0;
    end else begin
      state <= state_next;
      if (i_cmd_fire) begin
        is_msg <= (i_cmd_kind == CMD_MESSAGE);
      end
    end
  end

  assign o_cmd_accept   = (state == ST_IDLE);
  assign o_wdata_accept = (state == ST_DRAIN);
  assign o_resp_valid   = (state == ST_RESP);

endmodule

`default_nettype wire

/* dummy_target.sv */
// Answers every unmapped access with an error response and discards write data
`default_nettype none

module dummy_target (
  input  var logic                        i_clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_cmd_valid,
  input  var corebus_pkg::corebus_cmd_s   i_cmd,
  output logic                            o_cmd_accept,
  input  var logic                        i_wdata_valid,
  input  var corebus_pkg::corebus_wdata_s i_wdata,
  output logic                            o_wdata_accept,
  output logic                            o_resp_valid,
  output corebus_pkg::corebus_resp_s      o_resp,
  input  var logic                        i_resp_accept
);
  import corebus_pkg::*;

  logic          cmd_fire;
  logic          wdata_fire;
  logic          resp_fire;
  logic          resp_last;
  corebus_id_t   id_q;
  corebus_resp_e kind_q;

  assign cmd_fire   = i_cmd_valid && o_cmd_accept;
  assign wdata_fire = i_wdata_valid && o_wdata_accept;
  assign resp_fire  = o_resp_valid && i_resp_accept;

  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      id_q   <= i_cmd.id;
      kind_q <= (i_cmd.kind == CMD_READ) ? RESP_WITH_DATA : RESP_PLAIN;
    end
  end

  dummy_responder_fsm u_fsm (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_cmd_fire     (cmd_fire),
    .i_cmd_kind     (i_cmd.kind),
    .i_wdata_fire   (wdata_fire),
    .i_wdata_last   (i_wdata.last),
    .i_resp_fire    (resp_fire),
    .i_resp_last    (resp_last),
    .o_cmd_accept   (o_cmd_accept),
    .o_wdata_accept (o_wdata_accept),
    .o_resp_valid   (o_resp_valid)
  );

  // A write answers with a single beat
  beat_counter u_count (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_load  (cmd_fire),
    .i_len   ((i_cmd.kind == CMD_READ) ? i_cmd.len : corebus_len_t'(0)),
    .i_step  (resp_fire),
    .o_last  (resp_last)
  );

  always_comb begin
    o_resp.kind  = kind_q;
    o_resp.id    = id_q;
    o_resp.error = 1'b1;
    o_resp.data  = (kind_q == RESP_WITH_DATA) ? DUMMY_DATA : '0;
    o_resp.last  = resp_last;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_corebus -o tb_corebus
./obj_dir/tb_corebus

/* sram_target.sv */
// Sixteen-word memory with no reset on its contents and addresses wrap modulo 16
`default_nettype none

module sram_target (
  input  var logic                        i_clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_cmd_valid,
  input  var corebus_pkg::corebus_cmd_s   i_cmd,
  output logic                            o_cmd_accept,
  input  var logic                        i_wdata_valid,
  input  var corebus_pkg::corebus_wdata_s i_wdata,
  output logic                            o_wdata_accept,
  output logic                            o_resp_valid,
  output corebus_pkg::corebus_resp_s      o_resp,
  input  var logic                        i_resp_accept
);
  import corebus_pkg::*;

  typedef enum logic {
    SR_IDLE,
    SR_BUSY
  } sram_state_e;

  corebus_data_t                  mem [MEM_WORDS];
  sram_state_e                    state;
  corebus_cmd_e                   kind_q;
  corebus_id_t                    id_q;
  logic [$clog2(MEM_WORDS)-1:0]   idx; // Running word index
  logic                           resp_valid_q;
  logic                           cmd_fire;
  logic                           wdata_fire;
  logic                           resp_fire;
  logic                           resp_last;

  assign cmd_fire   = i_cmd_valid && o_cmd_accept;
  assign wdata_fire = i_wdata_valid && o_wdata_accept;
  assign resp_fire  = o_resp_valid && i_resp_accept;

  assign o_cmd_accept   = (state == SR_IDLE);
  assign o_wdata_accept = (state == SR_BUSY) && (kind_q != CMD_READ) && !resp_valid_q;
  assign o_resp_valid   = resp_valid_q;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= SR_IDLE;
      kind_q       <= CMD_READ;
      resp_valid_q <= 1'b0;
    end else if (cmd_fire) begin
      state        <= SR_BUSY;
      kind_q       <= i_cmd.kind;
      resp_valid_q <= (i_cmd.kind == CMD_READ); // Read data is ready next cycle
    end else if (wdata_fire && i_wdata.last) begin
      resp_valid_q <= (kind_q == CMD_WRITE);
      if (kind_q == CMD_MESSAGE) begin
        state <= SR_IDLE;
      end
    end else if (resp_fire && resp_last) begin
      state        <= SR_IDLE;
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      id_q <= i_cmd.id;
      idx  <= i_cmd.addr[$clog2(MEM_WORDS)-1:0];
    end else if (wdata_fire || resp_fire) begin
      idx <= idx + 1'b1;
    end
    if (wdata_fire) begin
      mem[idx] <= i_wdata.data;
    end
  end

  beat_counter u_count (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_load  (cmd_fire),
    .i_len   ((i_cmd.kind == CMD_READ) ? i_cmd.len : corebus_len_t'(0)),
    .i_step  (resp_fire),
    .o_last  (resp_last)
  );

  always_comb begin
    o_resp.kind  = (kind_q == CMD_READ) ? RESP_WITH_DATA : RESP_PLAIN;
    o_resp.id    = id_q;
    o_resp.error = 1'b0;
    o_resp.data  = (kind_q == CMD_READ) ? mem[idx] : '0;
    o_resp.last  = resp_last;
  end

endmodule

`default_nettype wire

/* src.f */
corebus_pkg.sv
beat_counter.sv
dummy_responder_fsm.sv
dummy_target.sv
sram_target.sv
corebus_router.sv
corebus_subsystem.sv
tb_corebus_sva.sv
tb_corebus.sv

/* tb_corebus.sv */
// Runs one transaction at a time and relies on the first directed writes to fill the memory
`default_nettype none

module tb_corebus;
  timeunit 1ns;
  timeprecision 1ns;

  import corebus_pkg::*;

  localparam int RAND_TXNS = 300;
  localparam int ALL_TXNS  = RAND_TXNS + 12; // Directed ones included

  logic           i_clk;
  logic           i_rst_n;
  logic           i_cmd_valid;
  corebus_cmd_s   i_cmd;
  logic           o_cmd_accept;
  logic           i_wdata_valid;
  corebus_wdata_s i_wdata;
  logic           o_wdata_accept;
  logic           o_resp_valid;
  corebus_resp_s  o_resp;
  logic           i_resp_accept;

  corebus_data_t  model_mem [MEM_WORDS];
  corebus_resp_s  exp_q [$];
  logic [31:0]    rng;
  logic [31:0]    bp_rng;
  logic           cmd_fired;   // Transfer seen on the last rising edge
  logic           wdata_fired;

  corebus_subsystem UUT (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_cmd_valid    (i_cmd_valid),
    .i_cmd          (i_cmd),
    .o_cmd_accept   (o_cmd_accept),
    .i_wdata_valid  (i_wdata_valid),
    .i_wdata        (i_wdata),
    .o_wdata_accept (o_wdata_accept),
    .o_resp_valid   (o_resp_valid),
    .o_resp         (o_resp),
    .i_resp_accept  (i_resp_accept)
  );

  always #50 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] next_random();
    rng = lcg_next(rng);
    return rng[31:16]; // Upper bits are the better ones
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  always @(posedge i_clk) begin
    cmd_fired   <= i_cmd_valid && o_cmd_accept;
    wdata_fired <= i_wdata_valid && o_wdata_accept;
  end

  // Response monitor
  always @(posedge i_clk) begin
    corebus_resp_s want;
    if (i_rst_n && o_resp_valid && i_resp_accept) begin
      if (exp_q.size() == 0) begin
        abort_run("a response arrived while no response was expected");
      end else begin
        want = exp_q.pop_front();
        check_value("o_resp.kind", o_resp.kind, want.kind);
        check_value("o_resp.id", o_resp.id, want.id);
        check_value("o_resp.error", o_resp.error, want.error);
        check_value("o_resp.data", o_resp.data, want.data);
        check_value("o_resp.last", o_resp.last, want.last);
      end
    end
  end

  always @(negedge i_clk) begin
    if (i_rst_n) begin
      bp_rng = lcg_next(bp_rng);
      i_resp_accept = (bp_rng[31:30] != 2'b00); // About one stall in four
    end
  end

  task automatic run_txn(input corebus_cmd_e kind, input corebus_id_t id,
                         input corebus_addr_t addr, input corebus_len_t len);
    int            beats;
    logic          to_mem;
    logic [3:0]    walk;
    corebus_resp_s r;
    corebus_data_t d;
    beats  = (kind == CMD_MESSAGE) ? 1 : int'(len) + 1;
    to_mem = (addr[7:4] == MEM_BASE_SEL);
    walk   = addr[3:0];
    if (kind == CMD_READ) begin
      for (int i = 0; i < beats; i++) begin
        r.kind  = RESP_WITH_DATA;
        r.id    = id;
        r.error = !to_mem;
        r.data  = to_mem ? model_mem[walk] : DUMMY_DATA;
        r.last  = (i == beats - 1);
        exp_q.push_back(r);
        walk = walk + 4'd1;
      end
    end else if (kind == CMD_WRITE) begin
      r.kind  = RESP_PLAIN;
      r.id    = id;
      r.error = !to_mem;
      r.data  = '0;
      r.last  = 1'b1;
      exp_q.push_back(r);
    end
    i_cmd.kind  = kind;
    i_cmd.id    = id;
    i_cmd.addr  = addr;
    i_cmd.len   = len;
    i_cmd_valid = 1'b1;
    @(negedge i_clk);
    while (!cmd_fired) @(negedge i_clk);
    i_cmd_valid = 1'b0;
    if (kind != CMD_READ) begin
      walk = addr[3:0];
      for (int b = 0; b < beats; b++) begin
        d[31:16]      = next_random();
        d[15:0]       = next_random();
        i_wdata.data  = d;
        i_wdata.last  = (b == beats - 1);
        i_wdata_valid = 1'b1;
        @(negedge i_clk);
        while (!wdata_fired) @(negedge i_clk);
        if (to_mem) begin
          model_mem[walk] = d;
        end
        walk = walk + 4'd1;
      end
      i_wdata_valid = 1'b0;
    end
    while (exp_q.size() != 0) @(negedge i_clk);
  endtask

  initial begin
    #(ALL_TXNS * 40 * 100);
    abort_run("watchdog expired before all transactions completed");
  end

  initial begin
    logic [15:0]   r;
    logic [15:0]   sel;
    corebus_cmd_e  kind;
    corebus_addr_t addr;
    i_clk         = 1'b0;
    i_rst_n       = 1'b0;
    i_cmd_valid   = 1'b0;
    i_cmd         = '0;
    i_wdata_valid = 1'b0;
    i_wdata       = '0;
    i_resp_accept = 1'b0;
    rng           = 32'd44;
    bp_rng        = lcg_next(32'd44);
    repeat (16) @(negedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    check_value("o_resp_valid", o_resp_valid, 1'b0);
    check_value("o_wdata_accept", o_wdata_accept, 1'b0);
    check_value("o_cmd_accept", o_cmd_accept, 1'b1);

    // Fill the whole memory first
    for (int a = 0; a < 16; a += 4) begin
      run_txn(CMD_WRITE, 4'(a), 8'(a), 2'd3);
    end
    run_txn(CMD_WRITE, 4'd1, 8'h0e, 2'd3); // Wraps past word 15
    run_txn(CMD_READ, 4'd2, 8'h0e, 2'd3);
    run_txn(CMD_READ, 4'd3, 8'h5a, 2'd2);
    run_txn(CMD_WRITE, 4'd4, 8'hc3, 2'd3);
    run_txn(CMD_READ, 4'd5, 8'h03, 2'd0);
    run_txn(CMD_MESSAGE, 4'd6, 8'h07, 2'd0);
    run_txn(CMD_MESSAGE, 4'd7, 8'hf1, 2'd0);
    run_txn(CMD_READ, 4'd8, 8'h07, 2'd0);

    for (int t = 0; t < RAND_TXNS; t++) begin
      r    = next_random();
      sel  = next_random();
      kind = corebus_cmd_e'(2'(r % 16'd3));
      if (sel[0]) begin
        addr = {MEM_BASE_SEL, sel[4:1]};
      end else begin
        addr = {4'(1 + int'(sel[15:5]) % 15), sel[4:1]};
      end
      run_txn(kind, r[7:4], addr, r[9:8]);
    end

    repeat (8) @(negedge i_clk); // A stray late response still reaches the monitor
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_corebus_sva.sv */
// Checks only the top-level response channel and needs assertions enabled in the simulator
`default_nettype none

module tb_corebus_sva (
  input var logic                       i_clk,
  input var logic                       i_rst_n,
  input var logic                       o_resp_valid,
  input var corebus_pkg::corebus_resp_s o_resp,
  input var logic                       i_resp_accept
);
  timeunit 1ns;
  timeprecision 1ns;

  resp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_resp_valid && !i_resp_accept) |=> (o_resp_valid && $stable(o_resp)))
    else $error("response dropped or changed under back-pressure");

  resp_quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !o_resp_valid)
    else $error("response valid during reset");

  // A burst continues from the same command until its last beat
  burst_whole: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_resp_valid && i_resp_accept && !o_resp.last) |=>
      (o_resp_valid && (o_resp.id == $past(o_resp.id)) &&
       (o_resp.kind == $past(o_resp.kind)) && (o_resp.error == $past(o_resp.error))))
    else $error("responses interleaved before a last beat");

endmodule

bind corebus_subsystem tb_corebus_sva u_sva (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .o_resp_valid  (o_resp_valid),
  .o_resp        (o_resp),
  .i_resp_accept (i_resp_accept)
);

`default_nettype wire
